//--- periph_pkg.sv
package periph_pkg;
	localparam int DATA_W = 8;
	localparam int ADDR_W = 8;
	// local offset seen by each device
	localparam int OFS_W = 3;
	localparam int KEY_N = 4;

	// clock block owns 0 to 7
	localparam logic [ADDR_W-1:0] ADDR_SEC = 8'd0;
	localparam logic [ADDR_W-1:0] ADDR_MIN = 8'd1;
	localparam logic [ADDR_W-1:0] ADDR_HOUR = 8'd2;
	localparam logic [ADDR_W-1:0] ADDR_CTL = 8'd3;
	localparam logic [ADDR_W-1:0] ADDR_LED = 8'd8;
	localparam logic [ADDR_W-1:0] ADDR_SW = 8'd9;
	localparam logic [ADDR_W-1:0] ADDR_KEY = 8'd10;
	localparam logic [ADDR_W-1:0] ADDR_BEEP = 8'd11;
	localparam logic [ADDR_W-1:0] ADDR_TICK = 8'd12;

	localparam int CLK_HZ = 25_000_000;
	localparam int DEF_TICK_CYCLES = CLK_HZ;
	localparam int DEF_LOCK_CYCLES = CLK_HZ / 2;
	localparam int DEF_SCAN_SHIFT = 15;
	// roughly a 2 kHz tone
	localparam int DEF_BEEP_HALF = CLK_HZ / 4000;
	localparam int FLASH_OFFSET = 8;

	// active-low, bit 7 is the decimal point
	localparam logic [7:0] SEG_DASH = 8'hbf;
	localparam logic [7:0] SEG_BLANK = 8'hff;

	function automatic logic [7:0] seg7_code(input logic [3:0] nib);
		case (nib)
			4'h0: seg7_code = 8'hc0;
			4'h1: seg7_code = 8'hf9;
			4'h2: seg7_code = 8'ha4;
			4'h3: seg7_code = 8'hb0;
			4'h4: seg7_code = 8'h99;
			4'h5: seg7_code = 8'h92;
			4'h6: seg7_code = 8'h82;
			4'h7: seg7_code = 8'hf8;
			4'h8: seg7_code = 8'h80;
			4'h9: seg7_code = 8'h90;
			4'ha: seg7_code = 8'h88;
			4'hb: seg7_code = 8'h83;
			4'hc: seg7_code = 8'ha7;
			4'hd: seg7_code = 8'ha1;
			4'he: seg7_code = 8'h86;
			default: seg7_code = 8'h8e;
		endcase
	endfunction
endpackage

//--- periph_if.sv
interface periph_if;
	import periph_pkg::*;

	logic wr;
	logic rd;
	logic [OFS_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	// registered by the device, zero when not read
	logic [DATA_W-1:0] rdata;

	modport bus (
		output wr,
		output rd,
		output addr,
		output wdata,
		input rdata
	);

	modport dev (
		input wr,
		input rd,
		input addr,
		input wdata,
		output rdata
	);
endinterface

//--- periph_bus.sv
module periph_bus (
	input logic clk,
	input logic rst,
	input logic wr_i,
	input logic rd_i,
	input logic [periph_pkg::ADDR_W-1:0] wr_addr_i,
	input logic [periph_pkg::ADDR_W-1:0] rd_addr_i,
	input logic [periph_pkg::DATA_W-1:0] din_i,
	output logic [periph_pkg::DATA_W-1:0] dout_o,
	periph_if.bus clk_bus,
	periph_if.bus io_bus,
	periph_if.bus in_bus,
	periph_if.bus tick_bus
);
	import periph_pkg::*;

	logic clk_wr;
	logic clk_rd;
	logic io_wr;
	logic io_rd;
	logic in_wr;
	logic in_rd;
	logic tick_wr;
	logic tick_rd;

	// clock block decodes on the upper bits only
	assign clk_wr = wr_i && wr_addr_i[ADDR_W-1:OFS_W] == ADDR_SEC[ADDR_W-1:OFS_W];
	assign clk_rd = rd_i && rd_addr_i[ADDR_W-1:OFS_W] == ADDR_SEC[ADDR_W-1:OFS_W];
	assign io_wr = wr_i && (wr_addr_i == ADDR_LED || wr_addr_i == ADDR_BEEP);
	assign io_rd = rd_i && (rd_addr_i == ADDR_LED || rd_addr_i == ADDR_BEEP);
	assign in_wr = wr_i && (wr_addr_i == ADDR_SW || wr_addr_i == ADDR_KEY);
	assign in_rd = rd_i && (rd_addr_i == ADDR_SW || rd_addr_i == ADDR_KEY);
	assign tick_wr = wr_i && wr_addr_i == ADDR_TICK;
	assign tick_rd = rd_i && rd_addr_i == ADDR_TICK;

	assign clk_bus.wr = clk_wr;
	assign clk_bus.rd = clk_rd;
	assign io_bus.wr = io_wr;
	assign io_bus.rd = io_rd;
	assign in_bus.wr = in_wr;
	assign in_bus.rd = in_rd;
	assign tick_bus.wr = tick_wr;
	assign tick_bus.rd = tick_rd;

	// the write address takes the offset when both strobe
	assign clk_bus.addr = clk_wr ? wr_addr_i[OFS_W-1:0] : rd_addr_i[OFS_W-1:0];
	assign io_bus.addr = io_wr ? wr_addr_i[OFS_W-1:0] : rd_addr_i[OFS_W-1:0];
	assign in_bus.addr = in_wr ? wr_addr_i[OFS_W-1:0] : rd_addr_i[OFS_W-1:0];
	assign tick_bus.addr = tick_wr ? wr_addr_i[OFS_W-1:0] : rd_addr_i[OFS_W-1:0];

	assign clk_bus.wdata = din_i;
	assign io_bus.wdata = din_i;
	assign in_bus.wdata = din_i;
	assign tick_bus.wdata = din_i;

	// each device drives zero unless it was read
	assign dout_o = clk_bus.rdata | io_bus.rdata | in_bus.rdata | tick_bus.rdata;
endmodule

//--- clock_regs.sv
module clock_regs (
	input logic clk,
	input logic rst,
	periph_if.dev bus,
	output logic [periph_pkg::DATA_W-1:0] sec_o,
	output logic [periph_pkg::DATA_W-1:0] min_o,
	output logic [periph_pkg::DATA_W-1:0] hour_o,
	output logic [periph_pkg::DATA_W-1:0] ctl_o
);
	import periph_pkg::*;

	logic [DATA_W-1:0] sec_q;
	logic [DATA_W-1:0] min_q;
	logic [DATA_W-1:0] hour_q;
	logic [DATA_W-1:0] ctl_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sec_q <= '0;
			min_q <= '0;
			hour_q <= '0;
			ctl_q <= '0;
		end
		else if (bus.wr)
		begin
			case (bus.addr)
				ADDR_SEC[OFS_W-1:0]: sec_q <= bus.wdata;
				ADDR_MIN[OFS_W-1:0]: min_q <= bus.wdata;
				ADDR_HOUR[OFS_W-1:0]: hour_q <= bus.wdata;
				ADDR_CTL[OFS_W-1:0]: ctl_q <= bus.wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || !bus.rd)
			bus.rdata <= '0;
		else
		begin
			case (bus.addr)
				ADDR_SEC[OFS_W-1:0]: bus.rdata <= sec_q;
				ADDR_MIN[OFS_W-1:0]: bus.rdata <= min_q;
				ADDR_HOUR[OFS_W-1:0]: bus.rdata <= hour_q;
				ADDR_CTL[OFS_W-1:0]: bus.rdata <= ctl_q;
				// offsets 4 to 7 are holes
				default: bus.rdata <= '0;
			endcase
		end
	end

	assign sec_o = sec_q;
	assign min_o = min_q;
	assign hour_o = hour_q;
	assign ctl_o = ctl_q;
endmodule

//--- seg7_scan.sv
module seg7_scan #(
	parameter int SCAN_SHIFT = periph_pkg::DEF_SCAN_SHIFT
) (
	input logic clk,
	input logic rst,
	input logic [periph_pkg::DATA_W-1:0] sec_i,
	input logic [periph_pkg::DATA_W-1:0] min_i,
	input logic [periph_pkg::DATA_W-1:0] hour_i,
	input logic [periph_pkg::DATA_W-1:0] ctl_i,
	output logic [7:0] seg7_sel_o,
	output logic [7:0] seg7_data_o
);
	import periph_pkg::*;

	localparam int CNT_W = SCAN_SHIFT + FLASH_OFFSET + 1;

	logic [CNT_W-1:0] scan_cnt;
	logic [2:0] k;
	logic flash;
	logic [7:0] code;

	always_ff @(posedge clk)
	begin
		if (rst)
			scan_cnt <= '0;
		else
			scan_cnt <= scan_cnt + CNT_W'(1);
	end

	assign k = scan_cnt[SCAN_SHIFT +: 3];
	// slow enough to see the blink
	assign flash = scan_cnt[SCAN_SHIFT + FLASH_OFFSET];

	// hh-mm-ss laid out right to left
	always_comb
	begin
		case (k)
			3'd0: code = seg7_code(sec_i[3:0]);
			3'd1: code = seg7_code(sec_i[7:4]);
			3'd2: code = SEG_DASH;
			3'd3: code = seg7_code(min_i[3:0]);
			3'd4: code = seg7_code(min_i[7:4]);
			3'd5: code = SEG_DASH;
			3'd6: code = seg7_code(hour_i[3:0]);
			default: code = seg7_code(hour_i[7:4]);
		endcase
	end

	// select and data follow the same index so they stay aligned
	always_ff @(posedge clk)
	begin
		seg7_sel_o <= ~(8'd1 << k);
		if (ctl_i[k] && flash)
			seg7_data_o <= SEG_BLANK;
		else
			seg7_data_o <= code;
	end
endmodule

//--- key_lock.sv
module key_lock #(
	parameter int LOCK_CYCLES = periph_pkg::DEF_LOCK_CYCLES
) (
	input logic clk,
	input logic rst,
	input logic key_i,
	input logic rd_i,
	output logic key_o
);
	localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

	typedef enum logic {
		IDLE,
		LOCK
	} state_t;

	state_t state;
	state_t state_nx;
	logic [CNT_W-1:0] cnt;
	logic cnt_done;

	assign cnt_done = cnt == CNT_W'(LOCK_CYCLES - 1);

	always_comb
	begin
		state_nx = state;
		case (state)
			IDLE:
				if (key_i && rd_i)
					state_nx = LOCK;
			default:
				if (cnt_done)
					state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			cnt <= '0;
		end
		else
		begin
			state <= state_nx;
			// counts only while locked
			cnt <= (state == LOCK) ? cnt + CNT_W'(1) : '0;
		end
	end

	assign key_o = key_i && state == IDLE;
endmodule

//--- input_port.sv
module input_port #(
	parameter int LOCK_CYCLES = periph_pkg::DEF_LOCK_CYCLES
) (
	input logic clk,
	input logic rst,
	periph_if.dev bus,
	input logic [periph_pkg::DATA_W-1:0] sw_i,
	input logic [periph_pkg::KEY_N-1:0] key_i
);
	import periph_pkg::*;

	logic [DATA_W-1:0] sw_q;
	logic [KEY_N-1:0] key_q;
	logic [KEY_N-1:0] key_free;
	logic key_rd;

	// pads come in asynchronous
	always_ff @(posedge clk)
	begin
		sw_q <= sw_i;
		key_q <= key_i;
	end

	assign key_rd = bus.rd && bus.addr == ADDR_KEY[OFS_W-1:0];

	for (genvar i = 0; i < KEY_N; i++)
	begin : g_key
		key_lock #(
			.LOCK_CYCLES(LOCK_CYCLES)
		) u_key_lock (
			.clk(clk),
			.rst(rst),
			.key_i(key_q[i]),
			.rd_i(key_rd),
			.key_o(key_free[i])
		);
	end

	always_ff @(posedge clk)
	begin
		if (rst || !bus.rd)
			bus.rdata <= '0;
		else if (bus.addr == ADDR_SW[OFS_W-1:0])
			bus.rdata <= sw_q;
		else if (key_rd)
			bus.rdata <= DATA_W'(key_free);
		else
			bus.rdata <= '0;
	end
endmodule

//--- output_port.sv
module output_port #(
	parameter int BEEP_HALF = periph_pkg::DEF_BEEP_HALF
) (
	input logic clk,
	input logic rst,
	periph_if.dev bus,
	output logic [7:0] led_o,
	output logic beep_o
);
	import periph_pkg::*;

	localparam int CNT_W = $clog2(BEEP_HALF + 1);

	logic [DATA_W-1:0] led_q;
	logic beep_en;
	logic [CNT_W-1:0] div_cnt;
	logic tone;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			led_q <= '0;
			beep_en <= 1'b0;
		end
		else if (bus.wr && bus.addr == ADDR_LED[OFS_W-1:0])
			led_q <= bus.wdata;
		else if (bus.wr && bus.addr == ADDR_BEEP[OFS_W-1:0])
			beep_en <= bus.wdata[0];
	end

	always_ff @(posedge clk)
	begin
		if (rst || !bus.rd)
			bus.rdata <= '0;
		else if (bus.addr == ADDR_LED[OFS_W-1:0])
			bus.rdata <= led_q;
		else
			bus.rdata <= DATA_W'(beep_en);
	end

	// square wave, restarts from low each time it is enabled
	always_ff @(posedge clk)
	begin
		if (rst || !beep_en)
		begin
			div_cnt <= '0;
			tone <= 1'b0;
		end
		else if (div_cnt == CNT_W'(BEEP_HALF - 1))
		begin
			div_cnt <= '0;
			tone <= ~tone;
		end
		else
			div_cnt <= div_cnt + CNT_W'(1);
	end

	assign led_o = led_q;
	assign beep_o = tone;
endmodule

//--- tick_gen.sv
module tick_gen #(
	parameter int TICK_CYCLES = periph_pkg::DEF_TICK_CYCLES
) (
	input logic clk,
	input logic rst,
	periph_if.dev bus
);
	import periph_pkg::*;

	localparam int CNT_W = $clog2(TICK_CYCLES + 1);

	logic [CNT_W-1:0] cnt;
	logic wrap;
	logic req;

	assign wrap = cnt == CNT_W'(TICK_CYCLES - 1);

	always_ff @(posedge clk)
	begin
		if (rst || wrap)
			cnt <= '0;
		else
			cnt <= cnt + CNT_W'(1);
	end

	// a new second beats a clear in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			req <= 1'b0;
		else if (wrap)
			req <= 1'b1;
		else if (bus.wr && !bus.wdata[0])
			req <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rst || !bus.rd)
			bus.rdata <= '0;
		else
			bus.rdata <= DATA_W'(req);
	end
endmodule

//--- devices_box.sv
module devices_box #(
	parameter int TICK_CYCLES = periph_pkg::DEF_TICK_CYCLES,
	parameter int LOCK_CYCLES = periph_pkg::DEF_LOCK_CYCLES,
	parameter int SCAN_SHIFT = periph_pkg::DEF_SCAN_SHIFT,
	parameter int BEEP_HALF = periph_pkg::DEF_BEEP_HALF
) (
	input logic clk,
	input logic rst,
	input logic wr_i,
	input logic rd_i,
	input logic [periph_pkg::ADDR_W-1:0] wr_addr_i,
	input logic [periph_pkg::ADDR_W-1:0] rd_addr_i,
	input logic [periph_pkg::DATA_W-1:0] din_i,
	input logic [periph_pkg::DATA_W-1:0] sw_i,
	input logic [periph_pkg::KEY_N-1:0] key_i,
	output logic [periph_pkg::DATA_W-1:0] dout_o,
	output logic [7:0] seg7_sel_o,
	output logic [7:0] seg7_data_o,
	output logic [7:0] led_o,
	output logic beep_o
);
	import periph_pkg::*;

	logic [DATA_W-1:0] sec;
	logic [DATA_W-1:0] min;
	logic [DATA_W-1:0] hour;
	logic [DATA_W-1:0] ctl;

	periph_if clk_bus ();
	periph_if io_bus ();
	periph_if in_bus ();
	periph_if tick_bus ();

	periph_bus u_bus (
		.clk(clk),
		.rst(rst),
		.wr_i(wr_i),
		.rd_i(rd_i),
		.wr_addr_i(wr_addr_i),
		.rd_addr_i(rd_addr_i),
		.din_i(din_i),
		.dout_o(dout_o),
		.clk_bus(clk_bus),
		.io_bus(io_bus),
		.in_bus(in_bus),
		.tick_bus(tick_bus)
	);

	clock_regs u_clock_regs (
		.clk(clk),
		.rst(rst),
		.bus(clk_bus),
		.sec_o(sec),
		.min_o(min),
		.hour_o(hour),
		.ctl_o(ctl)
	);

	seg7_scan #(
		.SCAN_SHIFT(SCAN_SHIFT)
	) u_seg7_scan (
		.clk(clk),
		.rst(rst),
		.sec_i(sec),
		.min_i(min),
		.hour_i(hour),
		.ctl_i(ctl),
		.seg7_sel_o(seg7_sel_o),
		.seg7_data_o(seg7_data_o)
	);

	input_port #(
		.LOCK_CYCLES(LOCK_CYCLES)
	) u_input_port (
		.clk(clk),
		.rst(rst),
		.bus(in_bus),
		.sw_i(sw_i),
		.key_i(key_i)
	);

	output_port #(
		.BEEP_HALF(BEEP_HALF)
	) u_output_port (
		.clk(clk),
		.rst(rst),
		.bus(io_bus),
		.led_o(led_o),
		.beep_o(beep_o)
	);

	tick_gen #(
		.TICK_CYCLES(TICK_CYCLES)
	) u_tick_gen (
		.clk(clk),
		.rst(rst),
		.bus(tick_bus)
	);
endmodule

//--- tb_devices_box.sv
module tb_devices_box;
	timeunit 1ns;
	timeprecision 100ps;
	import periph_pkg::*;

	localparam int TICK_N = 50;
	localparam int LOCK_N = 40;
	localparam int SHIFT_N = 2;
	localparam int BEEP_N = 3;
	// all tests together run a little over 4000 cycles
	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic rst;
	logic wr_i;
	logic rd_i;
	logic [ADDR_W-1:0] wr_addr_i;
	logic [ADDR_W-1:0] rd_addr_i;
	logic [DATA_W-1:0] din_i;
	logic [DATA_W-1:0] sw_i;
	logic [KEY_N-1:0] key_i;
	logic [DATA_W-1:0] dout_o;
	logic [7:0] seg7_sel_o;
	logic [7:0] seg7_data_o;
	logic [7:0] led_o;
	logic beep_o;

	integer seed = 32'h6294_10da;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [7:0] sec_v;
	logic [7:0] min_v;
	logic [7:0] hour_v;

	devices_box #(
		.TICK_CYCLES(TICK_N),
		.LOCK_CYCLES(LOCK_N),
		.SCAN_SHIFT(SHIFT_N),
		.BEEP_HALF(BEEP_N)
	) dut (
		.clk(clk),
		.rst(rst),
		.wr_i(wr_i),
		.rd_i(rd_i),
		.wr_addr_i(wr_addr_i),
		.rd_addr_i(rd_addr_i),
		.din_i(din_i),
		.sw_i(sw_i),
		.key_i(key_i),
		.dout_o(dout_o),
		.seg7_sel_o(seg7_sel_o),
		.seg7_data_o(seg7_data_o),
		.led_o(led_o),
		.beep_o(beep_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [7:0] random_byte();
		int r;
		r = $random(seed);
		random_byte = r[7:0];
	endfunction

	// display layout hh-mm-ss, digit 0 on the right
	function automatic logic [7:0] expected_digit(input logic [2:0] idx);
		case (idx)
			3'd0: expected_digit = seg7_code(sec_v[3:0]);
			3'd1: expected_digit = seg7_code(sec_v[7:4]);
			3'd3: expected_digit = seg7_code(min_v[3:0]);
			3'd4: expected_digit = seg7_code(min_v[7:4]);
			3'd6: expected_digit = seg7_code(hour_v[3:0]);
			3'd7: expected_digit = seg7_code(hour_v[7:4]);
			default: expected_digit = SEG_DASH;
		endcase
	endfunction

	task automatic expect_equal(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		wr_i = 1'b1;
		wr_addr_i = addr;
		din_i = data;
		@(negedge clk);
		wr_i = 1'b0;
	endtask

	// data shows up on dout_o one cycle after the strobe
	task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
		@(negedge clk);
		rd_i = 1'b1;
		rd_addr_i = addr;
		@(negedge clk);
		data = dout_o;
		rd_i = 1'b0;
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] got;
		bus_read(addr, got);
		expect_equal(got, exp, what);
	endtask

	task automatic readback_regs();
		logic [7:0] led_v;
		logic [7:0] ctl_v;
		logic [7:0] beep_v;
		for (int a = 0; a < 16; a++)
			read_expect(8'(a), 8'h00, $sformatf("address %0d after reset", a));
		read_expect(8'd200, 8'h00, "unmapped address 200");
		sec_v = random_byte();
		min_v = random_byte();
		hour_v = random_byte();
		ctl_v = random_byte();
		led_v = random_byte();
		beep_v = random_byte();
		bus_write(ADDR_SEC, sec_v);
		bus_write(ADDR_MIN, min_v);
		bus_write(ADDR_HOUR, hour_v);
		bus_write(ADDR_CTL, ctl_v);
		bus_write(ADDR_LED, led_v);
		bus_write(ADDR_BEEP, beep_v);
		expect_equal(dout_o, 8'h00, "dout after a write");
		read_expect(ADDR_SEC, sec_v, "sec read-back");
		read_expect(ADDR_MIN, min_v, "min read-back");
		read_expect(ADDR_HOUR, hour_v, "hour read-back");
		read_expect(ADDR_CTL, ctl_v, "ctl read-back");
		read_expect(ADDR_LED, led_v, "led read-back");
		read_expect(ADDR_BEEP, {7'd0, beep_v[0]}, "beep read-back");
		expect_equal(led_o, led_v, "led output");
		read_expect(8'd5, 8'h00, "clock hole at offset 5");
		read_expect(8'd13, 8'h00, "unmapped address 13");
		@(negedge clk);
		expect_equal(dout_o, 8'h00, "dout in a cycle after a non-read");
	endtask

	task automatic sample_scan(input int n, input logic blank_ok, output int blanks,
		output logic [7:0] seen);
		logic [2:0] k;
		int zeros;
		blanks = 0;
		seen = 8'h00;
		repeat (n)
		begin
			@(negedge clk);
			zeros = 0;
			k = 3'd0;
			for (int i = 0; i < 8; i++)
			begin
				if (!seg7_sel_o[i])
				begin
					zeros++;
					k = 3'(i);
				end
			end
			expect_equal(8'(zeros), 8'd1, "one digit selected");
			seen[k] = 1'b1;
			if (blank_ok && seg7_data_o === SEG_BLANK)
				blanks++;
			else
				expect_equal(seg7_data_o, expected_digit(k), $sformatf("digit %0d code", k));
		end
	endtask

	task automatic scan_display();
		int blanks;
		logic [7:0] seen;
		bus_write(ADDR_CTL, 8'h00);
		idle_cycles(2);
		// one scan is 32 cycles with the small shift
		sample_scan(200, 1'b0, blanks, seen);
		expect_equal(seen, 8'hff, "digits seen during scan");
	endtask

	task automatic flash_blanking();
		int blanks;
		logic [7:0] seen;
		bus_write(ADDR_CTL, 8'hff);
		idle_cycles(2);
		// flash bit flips every 1024 cycles
		sample_scan(2200, 1'b1, blanks, seen);
		expect_equal({7'd0, blanks > 0}, 8'd1, "blanked digits seen");
		expect_equal({7'd0, blanks < 2200}, 8'd1, "unblanked digits seen");
		bus_write(ADDR_CTL, 8'h00);
		idle_cycles(2);
		sample_scan(1100, 1'b0, blanks, seen);
		expect_equal(seen, 8'hff, "digits seen with flash off");
	endtask

	task automatic switch_and_keys();
		logic [7:0] sw_v;
		logic [7:0] held;
		int kidx;
		sw_v = random_byte();
		@(negedge clk);
		sw_i = sw_v;
		idle_cycles(2);
		read_expect(ADDR_SW, sw_v, "switch read");
		kidx = random_byte() % KEY_N;
		held = 8'd1 << kidx;
		@(negedge clk);
		key_i = held[KEY_N-1:0];
		idle_cycles(2);
		read_expect(ADDR_KEY, held, "first key read");
		read_expect(ADDR_KEY, 8'h00, "key read during lockout");
		idle_cycles(LOCK_N + 5);
		read_expect(ADDR_KEY, held, "key read after lockout");
		@(negedge clk);
		key_i = '0;
		idle_cycles(2);
		read_expect(ADDR_KEY, 8'h00, "key read after release");
	endtask

	task automatic tick_flag();
		logic [7:0] v;
		int polls;
		idle_cycles(TICK_N + 5);
		read_expect(ADDR_TICK, 8'h01, "tick flag after one period");
		bus_write(ADDR_TICK, 8'h00);
		// line up with a wrap so the next clear is far from the one after
		polls = 0;
		v = 8'h00;
		while (v != 8'h01 && polls < TICK_N)
		begin
			bus_read(ADDR_TICK, v);
			polls++;
		end
		expect_equal(v, 8'h01, "tick flag sets again");
		bus_write(ADDR_TICK, 8'h00);
		read_expect(ADDR_TICK, 8'h00, "tick flag after clear");
		idle_cycles(TICK_N / 4);
		read_expect(ADDR_TICK, 8'h00, "tick flag stays clear");
		idle_cycles(TICK_N + 5);
		read_expect(ADDR_TICK, 8'h01, "tick flag after next wrap");
		bus_write(ADDR_TICK, 8'h01);
		read_expect(ADDR_TICK, 8'h01, "write with bit 0 set keeps flag");
	endtask

	task automatic beep_stays_low(input int n, input string what);
		repeat (n)
		begin
			@(negedge clk);
			expect_equal({7'd0, beep_o}, 8'h00, what);
		end
	endtask

	task automatic beeper_tone();
		logic prev;
		int waited;
		bus_write(ADDR_BEEP, 8'h00);
		idle_cycles(2);
		beep_stays_low(100, "beep low while disabled");
		bus_write(ADDR_BEEP, 8'h01);
		waited = 0;
		while (beep_o == 1'b0 && waited < 4 * BEEP_N)
		begin
			@(negedge clk);
			waited++;
		end
		expect_equal({7'd0, beep_o}, 8'h01, "beep starts after enable");
		repeat (8)
		begin
			prev = beep_o;
			waited = 0;
			while (beep_o == prev && waited < 4 * BEEP_N)
			begin
				@(negedge clk);
				waited++;
			end
			expect_equal(8'(waited), 8'(BEEP_N), "beep half period");
		end
		bus_write(ADDR_BEEP, 8'h00);
		idle_cycles(2);
		beep_stays_low(50, "beep low after disable");
	endtask

	initial
	begin
		rst = 1'b1;
		wr_i = 1'b0;
		rd_i = 1'b0;
		wr_addr_i = '0;
		rd_addr_i = '0;
		din_i = '0;
		sw_i = '0;
		key_i = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		readback_regs();
		scan_display();
		flash_blanking();
		switch_and_keys();
		tick_flag();
		beeper_tone();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("TB FAILED");
		$finish;
	end
endmodule

//--- compile.f
periph_pkg.sv
periph_if.sv
periph_bus.sv
clock_regs.sv
seg7_scan.sv
key_lock.sv
input_port.sv
output_port.sv
tick_gen.sv
devices_box.sv
tb_devices_box.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_devices_box \
	-f compile.f -o tb_devices_box_sim &&
	{ out=$(./obj_dir/tb_devices_box_sim); echo "$out"; } &&
	echo "$out" | grep -qx "TB PASSED" &&
	echo "simulation ok" ||
	{ echo "simulation failed"; exit 1; }
